// File: Bender.yml
package:
  name: vga_scanout

sources:
  - src/vga_pkg.sv
  - src/mem_rd_if.sv
  - src/scan_if.sv
  - src/pixel_clk_div.sv
  - src/vga_timing.sv
  - src/line_fetcher.sv
  - src/line_buffer.sv
  - src/vga_top.sv
  - target: test
    files:
      - bench/vga_sva.sv
      - bench/tb_vga.sv

// File: bench/tb_vga.sv
`timescale 1ns/1ps

module tb_vga;

    localparam int unsigned PIX_CLKS  = 2;                          // presc 1
    localparam longint      WDOG_CLKS = 10 * 525 * 800 * PIX_CLKS;  // Ten frames against about eight
    localparam logic [19:0] FB1_ADDR  = 20'h40000;
    // Pixel samples at one per line in rising line order
    localparam int unsigned PT_Y [10] = '{0, 1, 5, 63, 100, 239, 240, 331, 479, 485};
    localparam int unsigned PT_X [10] = '{0, 1, 322, 639, 650, 17, 400, 5, 639, 100};

    logic        clk_i       = 1'b0;
    logic        nrst_i      = 1'b0;
    logic        enable_i    = 1'b0;
    logic [3:0]  presc_i     = 4'd1;
    logic [1:0]  scale_i     = 2'd1;
    logic        fb_sel_i    = 1'b0;
    logic        mem_valid_i = 1'b0;
    logic [7:0]  mem_data_i  = 8'h00;
    logic        mem_req_o;
    logic [19:0] mem_addr_o;
    logic [9:0]  mem_len_o;
    logic [7:0]  pixel_o;
    logic        hsync_o;
    logic        vsync_o;
    integer      seed   = 49525;
    int unsigned served = 0; // Words returned in the current burst

    always #5 clk_i = ~clk_i;

    vga_top i_dut (
        .clk_i       (clk_i),
        .nrst_i      (nrst_i),
        .enable_i    (enable_i),
        .presc_i     (presc_i),
        .scale_i     (scale_i),
        .fb_sel_i    (fb_sel_i),
        .mem_valid_i (mem_valid_i),
        .mem_data_i  (mem_data_i),
        .mem_req_o   (mem_req_o),
        .mem_addr_o  (mem_addr_o),
        .mem_len_o   (mem_len_o),
        .pixel_o     (pixel_o),
        .hsync_o     (hsync_o),
        .vsync_o     (vsync_o)
    );

    function automatic logic [7:0] mem_word(input logic [19:0] addr);
        return addr[7:0] ^ 8'hA5;
    endfunction

    function automatic logic [19:0] row_addr(input logic [19:0] base, input int unsigned row,
                                             input int unsigned s);
        return base + 20'(row * (640 >> s));
    endfunction

    function automatic logic [7:0] exp_pixel(input int unsigned x, input int unsigned y,
                                             input int unsigned s);
        if (x >= 640 || y >= 480) begin
            return 8'h00; // Blanking
        end
        return mem_word(row_addr(20'h0, y >> s, s) + 20'(x >> s));
    endfunction

    // Memory model with a one-in-four chance of a gap before each word
    always @(posedge clk_i) begin
        mem_valid_i <= 1'b0;
        if (mem_req_o !== 1'b1) begin
            served = 0;
        end else if (served < mem_len_o && ($random(seed) & 3) != 0) begin
            mem_valid_i <= 1'b1;
            mem_data_i  <= mem_word(mem_addr_o + 20'(served));
            served      = served + 1;
        end
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR: %s is 0x%0h, expected 0x%0h", name, got, exp);
            $display("Test FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic check_idle();
        check_val("mem_req_o", mem_req_o, 0);
        check_val("pixel_o", pixel_o, 0);
        check_val("hsync_o", hsync_o, 1);
        check_val("vsync_o", vsync_o, 0);
    endtask

    task automatic wait_req(output logic [19:0] addr, output logic [9:0] len);
        @(posedge mem_req_o);
        @(negedge clk_i);
        addr = mem_addr_o;
        len  = mem_len_o;
    endtask

    task automatic check_rows(input logic [19:0] base, input int unsigned first,
                              input int unsigned last);
        logic [19:0] addr;
        logic [9:0]  len;
        int unsigned r;
        for (r = first; r <= last; r++) begin
            wait_req(addr, len);
            check_val("mem_addr_o", addr, row_addr(base, r, 1));
            check_val("mem_len_o", len, 320);
        end
    endtask

    task automatic test_reset_idle();
        repeat (10) begin
            @(negedge clk_i);
            check_idle();
        end
        @(posedge clk_i);
        nrst_i <= 1'b1;
        repeat (20) begin
            @(negedge clk_i);
            check_idle(); // Out of reset but still disabled
        end
    endtask

    task automatic test_hsync_timing();
        int unsigned low_w;
        int unsigned period;
        @(negedge hsync_o);
        @(negedge clk_i);
        low_w = 0;
        do begin
            @(negedge clk_i);
            low_w++;
        end while (!hsync_o);
        period = low_w;
        do begin
            @(negedge clk_i);
            period++;
        end while (hsync_o);
        check_val("hsync_o low clocks", low_w, 96 * PIX_CLKS);
        check_val("hsync_o period clocks", period, 800 * PIX_CLKS);
    endtask

    task automatic test_vsync_timing();
        logic        prev_h;
        logic        prev_v;
        logic        done;
        int unsigned lines;
        int unsigned vs_lines;
        @(posedge vsync_o);
        @(negedge clk_i);
        prev_h   = hsync_o;
        prev_v   = vsync_o;
        lines    = 0;
        vs_lines = 0;
        do begin
            @(negedge clk_i);
            if (prev_h && !hsync_o) begin
                lines++;
                vs_lines += vsync_o;
            end
            done   = !prev_v && vsync_o;
            prev_h = hsync_o;
            prev_v = vsync_o;
        end while (!done);
        check_val("hsync_o pulses per frame", lines, 525);
        check_val("hsync_o pulses in vsync_o", vs_lines, 2);
    endtask

    task automatic test_fetch_frame();
        logic [19:0] addr;
        logic [9:0]  len;
        do begin
            wait_req(addr, len); // Skip to the fetch of row 0
        end while (addr != 20'h0);
        check_val("mem_len_o", len, 320);
        check_rows(20'h0, 1, 239);
        check_rows(20'h0, 0, 0); // Row 0 again closes a frame of 240 fetches
    endtask

    task automatic test_fb_switch();
        check_rows(20'h0, 1, 100);
        @(posedge clk_i);
        fb_sel_i <= 1'b1;
        check_rows(20'h0, 101, 239); // Old base until the frame ends
        check_rows(FB1_ADDR, 0, 1);
    endtask

    task automatic test_pixels(input int unsigned s);
        logic        prev_h;
        int unsigned falls;
        int unsigned idx;
        @(negedge mem_req_o);
        @(posedge clk_i);
        enable_i <= 1'b0;
        scale_i  <= 2'(s);
        fb_sel_i <= 1'b0;
        repeat (20) @(negedge clk_i);
        check_idle();
        @(posedge clk_i);
        enable_i <= 1'b1;
        // Samples come from the second frame after enable
        @(posedge vsync_o);
        @(negedge clk_i);
        prev_h = hsync_o;
        falls  = 0;
        idx    = 0;
        while (idx < 10) begin
            @(negedge clk_i);
            if (prev_h && !hsync_o) begin
                falls++;
                // Line 524 holds the 35th hsync pulse after vsync rises
                if (falls == 35 + PT_Y[idx]) begin
                    repeat ((144 + PT_X[idx]) * PIX_CLKS) @(negedge clk_i);
                    check_val($sformatf("pixel_o at x %0d y %0d", PT_X[idx], PT_Y[idx]),
                              pixel_o, exp_pixel(PT_X[idx], PT_Y[idx], s));
                    idx++;
                end
            end
            prev_h = hsync_o;
        end
    endtask

    initial begin
        repeat (WDOG_CLKS) @(posedge clk_i);
        $display("Timeout: the tests did not finish within %0d clock cycles", WDOG_CLKS);
        $display("Test FAILED");
        $fatal(1, "Watchdog expired");
    end

    always @(posedge clk_i) begin
        if (i_dut.i_sva.fail_cnt != 0) begin
            $display("A bound assertion on the memory port or hsync failed");
            $display("Test FAILED");
            $fatal(1, "Assertion failure");
        end
    end

    initial begin
        test_reset_idle();
        @(posedge clk_i);
        enable_i <= 1'b1;
        test_hsync_timing();
        test_vsync_timing();
        test_fetch_frame();
        test_fb_switch();
        test_pixels(0);
        test_pixels(2);
        if (i_dut.i_sva.fail_cnt == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("Test FAILED");
            $fatal(1, "%0d assertion failures", i_dut.i_sva.fail_cnt);
        end
    end

endmodule

// File: bench/vga_sva.sv
`timescale 1ns/1ps

module vga_sva (
    input logic                clk_i,
    input logic                nrst_i,
    input logic                enable_i,
    input vga_pkg::presc_t     presc_i,
    input logic                req_i,
    input vga_pkg::mem_addr_t  addr_i,
    input vga_pkg::burst_len_t len_i,
    input logic                hsync_i
);

    int unsigned     fail_cnt = 0;
    vga_pkg::presc_t presc_q;     // Divider setting in use
    int unsigned     hs_low_cnt;  // Clocks of hsync low so far

    always_ff @(posedge clk_i or negedge nrst_i) begin
        if (!nrst_i) begin
            presc_q    <= '0;
            hs_low_cnt <= 0;
        end else begin
            if (!enable_i) begin
                presc_q <= presc_i;
            end
            hs_low_cnt <= hsync_i ? 0 : hs_low_cnt + 1;
        end
    end

    a_req_stable: assert property (@(posedge clk_i) disable iff (!nrst_i)
        req_i && $past(req_i) |-> $stable(addr_i) && $stable(len_i))
    else begin
        $error("Burst address or length changed while req was high");
        fail_cnt++;
    end

    a_hsync_width: assert property (@(posedge clk_i) disable iff (!nrst_i || !enable_i)
        $rose(hsync_i) |-> hs_low_cnt == 96 * (presc_q + 1))
    else begin
        $error("hsync pulse lasted %0d clocks", hs_low_cnt);
        fail_cnt++;
    end

    a_req_enabled: assert property (@(posedge clk_i) disable iff (!nrst_i)
        $rose(req_i) |-> enable_i)
    else begin
        $error("Fetch request raised while disabled");
        fail_cnt++;
    end

endmodule

bind vga_top vga_sva i_sva (
    .clk_i    (clk_i),
    .nrst_i   (nrst_i),
    .enable_i (enable_i),
    .presc_i  (presc_i),
    .req_i    (mem_req_o),
    .addr_i   (mem_addr_o),
    .len_i    (mem_len_o),
    .hsync_i  (hsync_o)
);

// File: filelist.f
src/vga_pkg.sv
src/mem_rd_if.sv
src/scan_if.sv
src/pixel_clk_div.sv
src/vga_timing.sv
src/line_fetcher.sv
src/line_buffer.sv
src/vga_top.sv
bench/vga_sva.sv
bench/tb_vga.sv

// File: src/line_buffer.sv
`timescale 1ns/1ps

module line_buffer (
    input  logic            clk_i,
    input  logic            nrst_i,
    scan_if.sink            scan,
    input  logic            wr_en_i,
    input  vga_pkg::hpos_t  wr_addr_i,
    input  vga_pkg::pixel_t wr_data_i,
    output vga_pkg::pixel_t pixel_o
);

    vga_pkg::pixel_t bank_mem [2][vga_pkg::H_ACTIVE];

    logic            bank_q;     // Bank on display
    logic            swap_due_q; // Starting line begins a new source row
    logic            primed_q;   // A full frame has been fetched since reset
    logic            swap;
    logic            rd_bank;
    vga_pkg::hpos_t  rd_col;

    // The row fetched during a line is shown from the next line_start on
    assign swap    = scan.line_start && swap_due_q;
    assign rd_bank = swap ? ~bank_q : bank_q;
    assign rd_col  = scan.hpos >> scan.scale; // Pixel repeat

    always_ff @(posedge clk_i or negedge nrst_i) begin
        if (!nrst_i) begin
            bank_q     <= 1'b0;
            swap_due_q <= 1'b0;
            primed_q   <= 1'b0;
        end else begin
            if (scan.line_start) begin
                swap_due_q <= scan.next_row_new;
            end
            if (swap) begin
                bank_q <= ~bank_q;
            end
            if (scan.frame_start) begin
                primed_q <= 1'b1;
            end
        end
    end

    // Fetcher always fills the back bank
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            bank_mem[~bank_q][wr_addr_i] <= wr_data_i;
        end
    end

    always_ff @(posedge clk_i or negedge nrst_i) begin
        if (!nrst_i) begin
            pixel_o <= '0;
        end else if (scan.active && primed_q) begin
            pixel_o <= bank_mem[rd_bank][rd_col];
        end else begin
            pixel_o <= '0; // Blanking
        end
    end

endmodule

// File: src/line_fetcher.sv
`timescale 1ns/1ps

module line_fetcher (
    input  logic            clk_i,
    input  logic            nrst_i,
    input  logic            fb_sel_i,
    scan_if.sink            scan,
    mem_rd_if.fetch         mem,
    output logic            wr_en_o,
    output vga_pkg::hpos_t  wr_addr_o,
    output vga_pkg::pixel_t wr_data_o
);

    vga_pkg::fetch_state_t state_q;
    vga_pkg::mem_addr_t    addr_q;
    vga_pkg::burst_len_t   len_q;
    vga_pkg::hpos_t        word_cnt_q;
    logic                  fb_q;

    logic                  fb_use;
    vga_pkg::mem_addr_t    base;
    vga_pkg::mem_addr_t    src_row;
    vga_pkg::burst_len_t   src_width;
    vga_pkg::mem_addr_t    burst_addr;
    logic                  busy;
    logic                  last_word;

    // Buffer choice only changes with the fetch of line 0
    assign fb_use = (scan.next_vpos == '0) ? fb_sel_i : fb_q;
    assign base   = fb_use ? vga_pkg::FB1_BASE : vga_pkg::FB0_BASE;

    assign src_row    = vga_pkg::mem_addr_t'(scan.next_vpos) >> scan.scale;
    assign src_width  = vga_pkg::burst_len_t'(vga_pkg::H_ACTIVE >> scan.scale);
    assign burst_addr = base + src_row * vga_pkg::mem_addr_t'(src_width);

    assign busy      = (state_q != vga_pkg::IDLE);
    assign last_word = (word_cnt_q == len_q - 1'b1);

    always_ff @(posedge clk_i or negedge nrst_i) begin
        if (!nrst_i) begin
            state_q    <= vga_pkg::IDLE;
            addr_q     <= '0;
            len_q      <= '0;
            word_cnt_q <= '0;
            fb_q       <= 1'b0;
        end else begin
            case (state_q)
                vga_pkg::IDLE: begin
                    if (scan.line_start && scan.next_row_new) begin
                        state_q    <= vga_pkg::REQ;
                        addr_q     <= burst_addr;
                        len_q      <= src_width;
                        word_cnt_q <= '0;
                        fb_q       <= fb_use;
                    end
                end
                vga_pkg::REQ: begin
                    // Waiting for the first word
                    if (mem.valid) begin
                        word_cnt_q <= word_cnt_q + 1'b1;
                        state_q    <= vga_pkg::FILL;
                    end
                end
                vga_pkg::FILL: begin
                    if (mem.valid) begin
                        word_cnt_q <= word_cnt_q + 1'b1;
                        if (last_word) begin
                            state_q <= vga_pkg::IDLE; // req drops next cycle
                        end
                    end
                end
                default: state_q <= vga_pkg::IDLE;
            endcase
        end
    end

    assign mem.req  = busy;
    assign mem.addr = addr_q;
    assign mem.len  = len_q;

    // Word k of the burst lands in column k of the back bank
    assign wr_en_o   = busy && mem.valid;
    assign wr_addr_o = word_cnt_q;
    assign wr_data_o = mem.data;

endmodule

// File: src/mem_rd_if.sv
`timescale 1ns/1ps

// Burst read port, level request with a strobe per returned word
interface mem_rd_if;

    logic               req;
    vga_pkg::mem_addr_t addr;
    vga_pkg::burst_len_t len;
    logic               valid;
    vga_pkg::pixel_t    data;

    // Requesting side
    modport fetch (
        output req,
        output addr,
        output len,
        input  valid,
        input  data
    );

    // Memory side
    modport port (
        input  req,
        input  addr,
        input  len,
        output valid,
        output data
    );

endinterface

// File: src/pixel_clk_div.sv
`timescale 1ns/1ps

module pixel_clk_div (
    input  logic            clk_i,
    input  logic            nrst_i,
    input  logic            run_i,
    input  vga_pkg::presc_t presc_i,
    output logic            pix_en_o
);

    vga_pkg::presc_t presc_q;
    vga_pkg::presc_t cnt_q;

    always_ff @(posedge clk_i or negedge nrst_i) begin
        if (!nrst_i) begin
            presc_q <= '0;
            cnt_q   <= '0;
        end else if (!run_i) begin
            presc_q <= presc_i; // Setting only follows the pin while stopped
            cnt_q   <= '0;
        end else if (cnt_q == presc_q) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // One strobe per presc + 1 clocks
    assign pix_en_o = run_i && (cnt_q == presc_q);

endmodule

// File: src/scan_if.sv
`timescale 1ns/1ps

interface scan_if;

    vga_pkg::hpos_t  hpos;
    vga_pkg::vpos_t  vpos;
    logic            active;
    logic            pix_en;
    logic            line_start;   // First cycle of a new line, hpos already 0
    logic            next_row_new; // Line after the starting one needs a fresh source row
    vga_pkg::vpos_t  next_vpos;
    logic            frame_start;
    vga_pkg::scale_t scale;

    modport src (
        output hpos, vpos, active, pix_en, line_start,
        output next_row_new, next_vpos, frame_start, scale
    );

    modport sink (
        input hpos, vpos, active, pix_en, line_start,
        input next_row_new, next_vpos, frame_start, scale
    );

endinterface

// File: src/vga_pkg.sv
package vga_pkg;

    // Horizontal timing in pixel periods
    localparam int unsigned H_ACTIVE = 640;
    localparam int unsigned H_FPORCH = 16;
    localparam int unsigned H_SYNC   = 96;
    localparam int unsigned H_BPORCH = 48;
    localparam int unsigned H_TOTAL  = H_ACTIVE + H_FPORCH + H_SYNC + H_BPORCH;

    // Vertical timing in lines
    localparam int unsigned V_ACTIVE = 480;
    localparam int unsigned V_FPORCH = 10;
    localparam int unsigned V_SYNC   = 2;
    localparam int unsigned V_BPORCH = 33;
    localparam int unsigned V_TOTAL  = V_ACTIVE + V_FPORCH + V_SYNC + V_BPORCH;

    // Sync windows, start inclusive and end exclusive
    localparam int unsigned HS_START = H_ACTIVE + H_FPORCH;
    localparam int unsigned HS_END   = HS_START + H_SYNC;
    localparam int unsigned VS_START = V_ACTIVE + V_FPORCH;
    localparam int unsigned VS_END   = VS_START + V_SYNC;

    localparam logic HSYNC_ACT = 1'b0;
    localparam logic VSYNC_ACT = 1'b1;

    typedef logic [7:0]  pixel_t;     // One memory word per pixel
    typedef logic [9:0]  hpos_t;
    typedef logic [9:0]  vpos_t;
    typedef logic [19:0] mem_addr_t;  // Word address
    typedef logic [9:0]  burst_len_t;
    typedef logic [1:0]  scale_t;     // 0..3 gives 640, 320, 160, 80 pixels per line
    typedef logic [3:0]  presc_t;     // Pixel period is presc + 1 clocks

    // Framebuffer word addresses
    localparam mem_addr_t FB0_BASE = 20'h00000;
    localparam mem_addr_t FB1_BASE = 20'h40000;

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        FILL
    } fetch_state_t;

endpackage

// File: src/vga_timing.sv
`timescale 1ns/1ps

module vga_timing (
    input  logic            clk_i,
    input  logic            nrst_i,
    input  logic            enable_i,
    input  logic            pix_en_i,
    input  vga_pkg::scale_t scale_i,
    scan_if.src             scan,
    output logic            hsync_o,
    output logic            vsync_o
);

    vga_pkg::hpos_t  hcnt_q;
    vga_pkg::vpos_t  vcnt_q;
    vga_pkg::scale_t scale_q;
    logic            line_start_q;
    vga_pkg::vpos_t  next_vpos_q;

    logic            h_wrap;
    vga_pkg::vpos_t  v_inc;      // Line that starts at the next wrap
    vga_pkg::vpos_t  v_after;    // Line after that one
    logic [2:0]      row_mask;
    logic            hs_win;
    logic            vs_win;

    assign h_wrap  = (hcnt_q == vga_pkg::hpos_t'(vga_pkg::H_TOTAL - 1));
    assign v_inc   = (vcnt_q == vga_pkg::vpos_t'(vga_pkg::V_TOTAL - 1)) ? '0 : vcnt_q + 1'b1;
    assign v_after = (v_inc == vga_pkg::vpos_t'(vga_pkg::V_TOTAL - 1)) ? '0 : v_inc + 1'b1;

    always_ff @(posedge clk_i or negedge nrst_i) begin
        if (!nrst_i) begin
            hcnt_q       <= '0;
            vcnt_q       <= '0;
            scale_q      <= '0;
            line_start_q <= 1'b0;
            next_vpos_q  <= '0;
        end else if (!enable_i) begin
            hcnt_q       <= '0;
            vcnt_q       <= '0;
            scale_q      <= scale_i;
            line_start_q <= 1'b0;
        end else begin
            line_start_q <= 1'b0;
            if (pix_en_i) begin
                if (h_wrap) begin
                    hcnt_q       <= '0;
                    vcnt_q       <= v_inc;
                    line_start_q <= 1'b1;
                    next_vpos_q  <= v_after;
                end else begin
                    hcnt_q <= hcnt_q + 1'b1;
                end
            end
        end
    end

    assign hs_win = (hcnt_q >= vga_pkg::HS_START) && (hcnt_q < vga_pkg::HS_END);
    assign vs_win = (vcnt_q >= vga_pkg::VS_START) && (vcnt_q < vga_pkg::VS_END);

    // Same register stage as the pixel read-out in the line buffer
    always_ff @(posedge clk_i or negedge nrst_i) begin
        if (!nrst_i) begin
            hsync_o <= ~vga_pkg::HSYNC_ACT;
            vsync_o <= ~vga_pkg::VSYNC_ACT;
        end else begin
            hsync_o <= (enable_i && hs_win) ? vga_pkg::HSYNC_ACT : ~vga_pkg::HSYNC_ACT;
            vsync_o <= (enable_i && vs_win) ? vga_pkg::VSYNC_ACT : ~vga_pkg::VSYNC_ACT;
        end
    end

    // Low scale bits of the row number, zero on the first copy of a source row
    assign row_mask = 3'((4'd1 << scale_q) - 4'd1);

    assign scan.hpos         = hcnt_q;
    assign scan.vpos         = vcnt_q;
    assign scan.active       = enable_i && (hcnt_q < vga_pkg::H_ACTIVE)
                               && (vcnt_q < vga_pkg::V_ACTIVE);
    assign scan.pix_en       = pix_en_i;
    assign scan.line_start   = line_start_q;
    assign scan.next_vpos    = next_vpos_q;
    assign scan.next_row_new = (next_vpos_q < vga_pkg::V_ACTIVE)
                               && ((next_vpos_q[2:0] & row_mask) == 3'd0);
    assign scan.frame_start  = line_start_q && (vcnt_q == '0);
    assign scan.scale        = scale_q;

endmodule

// File: src/vga_top.sv
`timescale 1ns/1ps

module vga_top (
    input  logic                clk_i,
    input  logic                nrst_i,
    input  logic                enable_i,
    input  vga_pkg::presc_t     presc_i,
    input  vga_pkg::scale_t     scale_i,
    input  logic                fb_sel_i,
    input  logic                mem_valid_i,
    input  vga_pkg::pixel_t     mem_data_i,
    output logic                mem_req_o,
    output vga_pkg::mem_addr_t  mem_addr_o,
    output vga_pkg::burst_len_t mem_len_o,
    output vga_pkg::pixel_t     pixel_o,
    output logic                hsync_o,
    output logic                vsync_o
);

    logic            pix_en;
    logic            wr_en;
    vga_pkg::hpos_t  wr_addr;
    vga_pkg::pixel_t wr_data;

    scan_if   scan ();
    mem_rd_if mem ();

    // Memory port to pins
    assign mem_req_o  = mem.req;
    assign mem_addr_o = mem.addr;
    assign mem_len_o  = mem.len;
    assign mem.valid  = mem_valid_i;
    assign mem.data   = mem_data_i;

    pixel_clk_div i_div (
        .clk_i    (clk_i),
        .nrst_i   (nrst_i),
        .run_i    (enable_i),
        .presc_i  (presc_i),
        .pix_en_o (pix_en)
    );

    vga_timing i_timing (
        .clk_i    (clk_i),
        .nrst_i   (nrst_i),
        .enable_i (enable_i),
        .pix_en_i (pix_en),
        .scale_i  (scale_i),
        .scan     (scan.src),
        .hsync_o  (hsync_o),
        .vsync_o  (vsync_o)
    );

    line_fetcher i_fetch (
        .clk_i     (clk_i),
        .nrst_i    (nrst_i),
        .fb_sel_i  (fb_sel_i),
        .scan      (scan.sink),
        .mem       (mem.fetch),
        .wr_en_o   (wr_en),
        .wr_addr_o (wr_addr),
        .wr_data_o (wr_data)
    );

    line_buffer i_lbuf (
        .clk_i     (clk_i),
        .nrst_i    (nrst_i),
        .scan      (scan.sink),
        .wr_en_i   (wr_en),
        .wr_addr_i (wr_addr),
        .wr_data_i (wr_data),
        .pixel_o   (pixel_o)
    );

endmodule
